// File: qspi.f
+incdir+hw
hw/qspi_pkg.sv
hw/qspi_sequencer.sv
hw/qspi_sclk_gen.sv
hw/qspi_nibble_shifter.sv
hw/qspi_bus_regs.sv
hw/qspi.sv
verif/tb_clock.sv
verif/qspi_flash_model.sv
verif/qspi_sva.sv
verif/qspi_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module qspi_tb -f qspi.f &&
  ./obj_dir/Vqspi_tb | tee /dev/stderr | grep -qx "STATUS: PASS" &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }

// File: verif/qspi_golden.txt
# op addr wdata dev_byte exp_rdata exp_err gap, all hex except gap; op 1 write, 0 read
# gap is idle cycles before the request, 0 raises valid again at once after ready
0 00000004 00000000 00 00000001 0 1
1 00000000 000000a5 00 00000000 0 1
0 00000000 00000000 3c 0000003c 0 1
1 00000004 00000003 00 00000000 0 1
0 00000004 00000000 00 00000003 0 0
1 00000000 1234565a 00 00000000 0 1
0 00000000 00000000 e7 000000e7 0 2
0 00000008 00000000 00 00000000 1 1
1 00000010 000000ff 00 00000000 1 0
0 0000000c 00000000 00 00000000 1 3
1 00000000 000000c3 00 00000000 0 0
0 00000000 00000000 81 00000081 0 0
1 00000004 00000001 00 00000000 0 0
1 00000000 0000000f 00 00000000 0 0
0 00000000 00000000 96 00000096 0 0

// File: verif/qspi_tb.sv
`timescale 1ns/100ps

`include "qspi_macros.svh"

module qspi_tb;

  logic        clock;
  logic        reset;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        mem_error;
  logic        sclk;
  logic        cs;
  wire         d0;
  wire         d1;
  wire         d2;
  wire         d3;
  logic        read_en;
  logic [7:0]  read_byte;
  logic [7:0]  captured_byte;
  logic [15:0] capture_count;
  int          errors;
  int          checks;
  int          cur_div;
  int          period_errors = 0;
  int          period_checks = 0;
  int          half_count = 0;
  logic        sclk_prev = 1'b0;
  logic        have_toggle = 1'b0;

  tb_clock u_clock (.clock(clock));

  qspi u_qspi (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .mem_error (mem_error),
    .sclk      (sclk),
    .cs        (cs),
    .d0        (d0),
    .d1        (d1),
    .d2        (d2),
    .d3        (d3)
  );

  qspi_flash_model u_flash (
    .sclk          (sclk),
    .cs            (cs),
    .d0            (d0),
    .d1            (d1),
    .d2            (d2),
    .d3            (d3),
    .read_en       (read_en),
    .read_byte     (read_byte),
    .captured_byte (captured_byte),
    .capture_count (capture_count)
  );

  // Every sclk half-period inside a frame lasts div+1 cycles
  always @(posedge clock) begin
    if (sclk != sclk_prev) begin
      if (have_toggle) begin
        period_checks++;
        if (half_count != cur_div + 1) begin
          period_errors++;
          $display("ERROR sclk half-period: got 0x%0h cycles, expected 0x%0h",
                   half_count, cur_div + 1);
        end
      end
      have_toggle = 1'b1;
      half_count = 1;
    end else if (cs) begin
      have_toggle = 1'b0;
    end else begin
      half_count++;
    end
    sclk_prev = sclk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic run_access(input int op, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [7:0] dev, input logic [31:0] exp_rdata,
                            input logic exp_err, input int gap, output logic ok);
    int          cycles;
    logic        is_data;
    logic [15:0] count_before;
    is_data = (addr == 32'(`QSPI_DATA_ADDR));
    count_before = capture_count;
    if (gap > 0) begin
      mem_valid <= 1'b0;
      repeat (gap) @(posedge clock);
    end
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= (op == 1) ? 4'hf : 4'h0;
    read_en   <= (op == 0);
    read_byte <= dev;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < 200) begin
      @(posedge clock);
      cycles++;
      if (!is_data && !cs) begin
        errors++;
        $display("Chip select fell during an access to address 0x%0h", addr);
      end
      ok = mem_ready;
    end
    if (!ok) begin
      errors++;
      $display("Timed out waiting for mem_ready on address 0x%0h", addr);
    end else begin
      if (!is_data) begin
        check_value("mem_ready latency", cycles, 32'd2);
      end
      check_value("mem_error", 32'(mem_error), 32'(exp_err));
      if (op == 0) begin
        check_value("mem_rdata", mem_rdata, exp_rdata);
      end
      if (is_data && op == 1 && !exp_err) begin
        check_value("capture_count", 32'(capture_count), 32'(count_before + 16'd1));
        check_value("captured_byte", 32'(captured_byte), 32'(wdata[7:0]));
      end
      // Track the divider for the half-period monitor
      if (addr == 32'(`QSPI_DIV_ADDR) && op == 1 && !exp_err) begin
        cur_div = int'(wdata[7:0]);
      end
    end
  endtask

  initial begin
    string       line;
    int          fd;
    int          n;
    int          op;
    int          gap;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [7:0]  dev;
    logic        exp_err;
    logic        ok;
    errors = 0;
    checks = 0;
    cur_div = `QSPI_DEFAULT_DIV;
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_addr = 32'h0;
    mem_wdata = 32'h0;
    mem_wstrb = 4'h0;
    read_en = 1'b0;
    read_byte = 8'h00;
    ok = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    check_value("cs", 32'(cs), 32'h1);
    check_value("sclk", 32'(sclk), 32'h0);
    check_value("mem_ready", 32'(mem_ready), 32'h0);
    fd = $fopen("verif/qspi_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the golden file");
    end else begin
      while (ok && !$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %d",
                      op, addr, wdata, dev, exp_rdata, exp_err, gap);
          if (n == 7) begin
            run_access(op, addr, wdata, dev, exp_rdata, exp_err, gap, ok);
          end
        end
      end
      $fclose(fd);
    end
    mem_valid <= 1'b0;
    $display("Checks: %0d, errors: %0d, sclk checks: %0d, sclk errors: %0d",
             checks, errors, period_checks, period_errors);
    if (errors == 0 && period_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/qspi_sva.sv
`timescale 1ns/100ps

module qspi_sva (
  input logic clock,
  input logic reset,
  input logic mem_ready,
  input logic cs,
  input logic sclk,
  input logic drive,
  input logic run
);

  // Ready is a single-cycle pulse
  a_ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |=> !mem_ready)
    else $error("mem_ready stayed high for a second cycle");

  // Pads are driven only inside a selected frame with sclk running
  a_pads_idle: assert property (@(posedge clock) disable iff (!reset)
    drive |-> (!cs && run))
    else $error("data pads driven while cs is high or sclk is stopped");

  a_sclk_idle: assert property (@(posedge clock) disable iff (!reset)
    (cs && $past(cs)) |-> $stable(sclk))
    else $error("sclk toggled while cs is high");

endmodule

bind qspi qspi_sva u_qspi_sva (
  .clock     (clock),
  .reset     (reset),
  .mem_ready (mem_ready),
  .cs        (cs),
  .sclk      (sclk),
  .drive     (drive),
  .run       (run)
);

// File: verif/qspi_flash_model.sv
`timescale 1ns/100ps

module qspi_flash_model (
  input  logic        sclk,
  input  logic        cs,
  inout  wire         d0,
  inout  wire         d1,
  inout  wire         d2,
  inout  wire         d3,
  input  logic        read_en,
  input  logic [7:0]  read_byte,
  output logic [7:0]  captured_byte,
  output logic [15:0] capture_count
);

  logic [7:0]  last_byte = 8'h00;
  logic [15:0] byte_count = 16'h0000;
  logic [3:0]  high_nibble = 4'h0;
  logic        second = 1'b0;
  logic        low_half = 1'b0;
  logic [3:0]  out_nibble;
  logic        out_en;

  // Written nibbles are taken on rising sclk, frame ends with cs high
  always @(posedge sclk or posedge cs) begin
    if (cs) begin
      second <= 1'b0;
    end else if (!read_en) begin
      if (!second) begin
        high_nibble <= {d3, d2, d1, d0};
        second      <= 1'b1;
      end else begin
        last_byte  <= {high_nibble, d3, d2, d1, d0};
        byte_count <= byte_count + 16'd1;
        second     <= 1'b0;
      end
    end
  end

  // Low nibble goes out after the first falling edge
  always @(negedge sclk or posedge cs) begin
    if (cs) begin
      low_half <= 1'b0;
    end else begin
      low_half <= 1'b1;
    end
  end

  assign out_en = read_en && !cs;
  assign out_nibble = low_half ? read_byte[3:0] : read_byte[7:4];

  assign d0 = out_en ? out_nibble[0] : 1'bz;
  assign d1 = out_en ? out_nibble[1] : 1'bz;
  assign d2 = out_en ? out_nibble[2] : 1'bz;
  assign d3 = out_en ? out_nibble[3] : 1'bz;

  assign captured_byte = last_byte;
  assign capture_count = byte_count;

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clock
);

  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

endmodule

// File: hw/qspi.sv
`timescale 1ns/100ps

`include "qspi_macros.svh"

module qspi (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        mem_valid,
  input  logic [`QSPI_ADDR_WIDTH-1:0] mem_addr,
  input  logic [`QSPI_DATA_WIDTH-1:0] mem_wdata,
  input  logic [3:0]                  mem_wstrb,
  output logic [`QSPI_DATA_WIDTH-1:0] mem_rdata,
  output logic                        mem_ready,
  output logic                        mem_error,
  output logic                        sclk,
  output logic                        cs,
  inout  wire                         d0,
  inout  wire                         d1,
  inout  wire                         d2,
  inout  wire                         d3
);

  qspi_pkg::bus_op_t          op;
  logic [7:0]                 tx_byte;
  logic [7:0]                 rx_byte;
  logic [`QSPI_DIV_WIDTH-1:0] div;
  logic                       run;
  logic                       rise;
  logic                       fall;
  logic                       load;
  logic                       shift;
  logic                       sample;
  logic                       drive;
  logic                       busy;
  logic                       xfer_done;
  logic [3:0]                 d_in;
  logic [3:0]                 d_out;

  qspi_bus_regs u_bus_regs (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .busy      (busy),
    .xfer_done (xfer_done),
    .rx_byte   (rx_byte),
    .op        (op),
    .tx_byte   (tx_byte),
    .div       (div),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .mem_error (mem_error)
  );

  qspi_sequencer u_sequencer (
    .clock     (clock),
    .reset     (reset),
    .op        (op),
    .rise      (rise),
    .fall      (fall),
    .run       (run),
    .load      (load),
    .shift     (shift),
    .sample    (sample),
    .drive     (drive),
    .cs        (cs),
    .busy      (busy),
    .xfer_done (xfer_done)
  );

  qspi_sclk_gen u_sclk_gen (
    .clock (clock),
    .reset (reset),
    .run   (run),
    .div   (div),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

  qspi_nibble_shifter u_shifter (
    .clock   (clock),
    .reset   (reset),
    .load    (load),
    .tx_byte (tx_byte),
    .shift   (shift),
    .sample  (sample),
    .d_in    (d_in),
    .d_out   (d_out),
    .rx_byte (rx_byte)
  );

  // d0 carries the lowest bit of each nibble
  assign d_in = {d3, d2, d1, d0};

  // Pads float unless a write is in progress
  assign d0 = drive ? d_out[0] : 1'bz;
  assign d1 = drive ? d_out[1] : 1'bz;
  assign d2 = drive ? d_out[2] : 1'bz;
  assign d3 = drive ? d_out[3] : 1'bz;

endmodule

// File: hw/qspi_bus_regs.sv
`timescale 1ns/100ps

`include "qspi_macros.svh"

module qspi_bus_regs (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        mem_valid,
  input  logic [`QSPI_ADDR_WIDTH-1:0] mem_addr,
  input  logic [`QSPI_DATA_WIDTH-1:0] mem_wdata,
  input  logic [3:0]                  mem_wstrb,
  input  logic                        busy,
  input  logic                        xfer_done,
  input  logic [7:0]                  rx_byte,
  output qspi_pkg::bus_op_t           op,
  output logic [7:0]                  tx_byte,
  output logic [`QSPI_DIV_WIDTH-1:0]  div,
  output logic [`QSPI_DATA_WIDTH-1:0] mem_rdata,
  output logic                        mem_ready,
  output logic                        mem_error
);

  logic accept;
  logic is_write;
  logic reg_op;
  logic last_read;

  // Hold off while a transfer runs or its ready is still out
  assign accept = mem_valid && !busy && !mem_ready;
  assign is_write = |mem_wstrb;

  always_comb begin
    op = qspi_pkg::none;
    if (accept) begin
      if (mem_addr == `QSPI_ADDR_WIDTH'(`QSPI_DATA_ADDR)) begin
        op = is_write ? qspi_pkg::data_write : qspi_pkg::data_read;
      end else if (mem_addr == `QSPI_ADDR_WIDTH'(`QSPI_DIV_ADDR)) begin
        op = is_write ? qspi_pkg::div_write : qspi_pkg::div_read;
      end else begin
        op = qspi_pkg::bad_addr;
      end
    end
  end

  assign tx_byte = mem_wdata[7:0];

  assign reg_op = (op == qspi_pkg::div_write) || (op == qspi_pkg::div_read) ||
                  (op == qspi_pkg::bad_addr);

  always_ff @(posedge clock) begin
    if (!reset) begin
      div       <= `QSPI_DIV_WIDTH'(`QSPI_DEFAULT_DIV);
      mem_ready <= 1'b0;
      mem_error <= 1'b0;
      last_read <= 1'b0;
    end else begin
      mem_ready <= reg_op || xfer_done;
      mem_error <= (op == qspi_pkg::bad_addr);
      if (op == qspi_pkg::div_write) begin
        // Zero is not a legal half-period
        div <= (mem_wdata[7:0] == 8'h00) ? `QSPI_DIV_WIDTH'(1) : mem_wdata[7:0];
      end
      if (op == qspi_pkg::data_read) begin
        last_read <= 1'b1;
      end else if (op == qspi_pkg::data_write) begin
        last_read <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (op == qspi_pkg::div_read) begin
      mem_rdata <= `QSPI_DATA_WIDTH'(div);
    end else if (reg_op) begin
      mem_rdata <= '0;
    end else if (xfer_done) begin
      mem_rdata <= last_read ? `QSPI_DATA_WIDTH'(rx_byte) : '0;
    end
  end

endmodule

// File: hw/qspi_nibble_shifter.sv
`timescale 1ns/100ps

module qspi_nibble_shifter (
  input  logic       clock,
  input  logic       reset,
  input  logic       load,
  input  logic [7:0] tx_byte,
  input  logic       shift,
  input  logic       sample,
  input  logic [3:0] d_in,
  output logic [3:0] d_out,
  output logic [7:0] rx_byte
);

  logic [7:0] data;
  logic [7:0] data_next;

  always_comb begin
    data_next = data;
    if (load) begin
      data_next = tx_byte;
    end else begin
      // Sample lands in the low nibble ahead of any shift
      if (sample) begin
        data_next[3:0] = d_in;
      end
      if (shift) begin
        data_next = {data_next[3:0], 4'b0000};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      data <= 8'h00;
    end else begin
      data <= data_next;
    end
  end

  // High nibble goes out first
  assign d_out = data[7:4];

  assign rx_byte = data;

endmodule

// File: hw/qspi_sclk_gen.sv
`timescale 1ns/100ps

`include "qspi_macros.svh"

module qspi_sclk_gen (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       run,
  input  logic [`QSPI_DIV_WIDTH-1:0] div,
  output logic                       sclk,
  output logic                       rise,
  output logic                       fall
);

  logic [`QSPI_DIV_WIDTH-1:0] count;
  logic                       wrap;

  // Half-period is div+1 cycles
  assign wrap = run && (count == div);

  // Strobes flag the cycle before sclk changes
  assign rise = wrap && !sclk;
  assign fall = wrap && sclk;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      sclk  <= 1'b0;
    end else if (!run) begin
      // Idle low between transfers
      count <= '0;
      sclk  <= 1'b0;
    end else if (wrap) begin
      count <= '0;
      sclk  <= ~sclk;
    end else begin
      count <= count + `QSPI_DIV_WIDTH'(1);
    end
  end

endmodule

// File: hw/qspi_sequencer.sv
`timescale 1ns/100ps

module qspi_sequencer (
  input  logic              clock,
  input  logic              reset,
  input  qspi_pkg::bus_op_t op,
  input  logic              rise,
  input  logic              fall,
  output logic              run,
  output logic              load,
  output logic              shift,
  output logic              sample,
  output logic              drive,
  output logic              cs,
  output logic              busy,
  output logic              xfer_done
);

  qspi_pkg::seq_state_t state;
  qspi_pkg::seq_state_t state_next;
  logic                 reading;
  logic                 accept;

  // Only an idle sequencer takes a data access
  assign accept = (state == qspi_pkg::idle) &&
                  ((op == qspi_pkg::data_write) || (op == qspi_pkg::data_read));

  // Serial clock runs for both nibble phases
  assign run = (state == qspi_pkg::shift_high) || (state == qspi_pkg::shift_low);

  assign load = (state == qspi_pkg::idle) && (op == qspi_pkg::data_write);

  // Only one shift, between the two nibbles
  assign shift = (state == qspi_pkg::shift_high) && fall;

  // Read data is taken on the rising strobe
  assign sample = run && reading && rise;

  assign busy = (state != qspi_pkg::idle);
  assign xfer_done = (state == qspi_pkg::done);

  always_comb begin
    state_next = state;
    case (state)
      qspi_pkg::idle: begin
        if (accept) begin
          state_next = qspi_pkg::shift_high;
        end
      end
      qspi_pkg::shift_high: begin
        if (fall) begin
          state_next = qspi_pkg::shift_low;
        end
      end
      qspi_pkg::shift_low: begin
        if (fall) begin
          state_next = qspi_pkg::done;
        end
      end
      qspi_pkg::done: begin
        state_next = qspi_pkg::idle;
      end
      default: begin
        state_next = qspi_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= qspi_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // Chip select and pad enable change together
  always_ff @(posedge clock) begin
    if (!reset) begin
      cs      <= 1'b1;
      drive   <= 1'b0;
      reading <= 1'b0;
    end else if (accept) begin
      cs      <= 1'b0;
      drive   <= (op == qspi_pkg::data_write);
      reading <= (op == qspi_pkg::data_read);
    end else if ((state == qspi_pkg::shift_low) && fall) begin
      // End of second nibble
      cs    <= 1'b1;
      drive <= 1'b0;
    end
  end

endmodule

// File: hw/qspi_pkg.sv
package qspi_pkg;

  // Transfer sequencer states
  typedef enum logic [1:0] {
    idle       = 2'd0,
    shift_high = 2'd1,
    shift_low  = 2'd2,
    done       = 2'd3
  } seq_state_t;

  // Decoded bus access
  typedef enum logic [2:0] {
    none       = 3'd0,
    data_write = 3'd1,
    data_read  = 3'd2,
    div_write  = 3'd3,
    div_read   = 3'd4,
    bad_addr   = 3'd5
  } bus_op_t;

endpackage

// File: hw/qspi_macros.svh
`ifndef QSPI_MACROS_SVH
`define QSPI_MACROS_SVH

// Processor bus widths
`define QSPI_DATA_WIDTH 32
`define QSPI_ADDR_WIDTH 32

// Register map
`define QSPI_DATA_ADDR 0
`define QSPI_DIV_ADDR 4

// Serial clock half-period in cycles, minus one
`define QSPI_DIV_WIDTH 8
`define QSPI_DEFAULT_DIV 1

`endif
